/* src/spw_pkg.sv */
//----------------------------
// SpaceWire receive path shared types
// Character and APB structs, register map
// and the link credit constants
//----------------------------
`default_nettype none

package spw_pkg;

	//----------------------------
	// Link characters
	//----------------------------

	// Flag 0 is a data byte, flag 1 an end-of-packet marker
	typedef struct packed {
		logic       flag;
		logic [7:0] code;
	} spw_char_t;

	//----------------------------
	// APB bus
	//----------------------------

	typedef struct packed {
		logic        sel;
		logic        enable;
		logic        write;
		logic [11:0] addr;
		logic [31:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
		logic        slverr;
	} apb_rsp_t;

	// Register offsets
	localparam logic [11:0] REG_DATA    = 12'h000;
	localparam logic [11:0] REG_STATUS  = 12'h004;
	localparam logic [11:0] REG_CONTROL = 12'h008;

	// Characters granted by one FCT
	localparam int FCT_CREDIT = 8;
	// Upper bound on credit the far end may hold
	localparam int MAX_CREDIT = 56;

endpackage

`default_nettype wire

/* src/spw_rx_fifo.sv */
//----------------------------
// Receive character FIFO
// Circular buffer with a registered
// show-ahead head, fill count and flags
//----------------------------
`default_nettype none
`timescale 1ns/100ps

module spw_rx_fifo #(
	parameter int depth_log2 = 6
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                write,
	input  spw_pkg::spw_char_t  wdata,
	input  logic                pop,
	output spw_pkg::spw_char_t  head,
	output logic [depth_log2:0] count,
	output logic                empty,
	output logic                full
);
	import spw_pkg::*;

	localparam int depth = 2 ** depth_log2;

	spw_char_t             mem [depth];
	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	logic [depth_log2-1:0] rd_next;
	logic [depth_log2:0]   count_next;

	//----------------------------
	// Storage and pointers
	//----------------------------

	always_ff @(posedge clock)
	begin
		if (write)
		begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Read pointer as it stands after this edge
	assign rd_next = rd_ptr + depth_log2'(pop);

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (write)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_next;
		end
	end

	// Head follows the next read slot; bypass when that slot is being written
	always_ff @(posedge clock)
	begin
		if (write && wr_ptr == rd_next)
		begin
			head <= wdata;
		end
		else
		begin
			head <= mem[rd_next];
		end
	end

	//----------------------------
	// Fill count and flags
	//----------------------------

	always_comb
	begin
		case ({write, pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			count <= '0;
			empty <= 1'b1;
			full  <= 1'b0;
		end
		else
		begin
			count <= count_next;
			empty <= (count_next == '0);
			full  <= (count_next == (depth_log2 + 1)'(depth));
		end
	end

	//----------------------------
	// Checks
	//----------------------------

	// Credit must keep the link from overrunning the buffer
	write_while_full : assert property (
		@(posedge clock) disable iff (!reset)
		write |-> !full
	) else $error("FIFO written while full");

	// Host side may only pop a stored character
	pop_while_empty : assert property (
		@(posedge clock) disable iff (!reset)
		pop |-> !empty
	) else $error("FIFO popped while empty");

endmodule

`default_nettype wire

/* src/spw_credit_tracker.sv */
//----------------------------
// Link credit tracker
// Counts outstanding credit, requests FCTs
// and flags characters sent without credit
//----------------------------
`default_nettype none
`timescale 1ns/100ps

module spw_credit_tracker #(
	parameter int depth_log2 = 6
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                rx_valid,
	input  logic [depth_log2:0] count,
	input  logic                link_enable,
	input  logic                fct_ack,
	input  logic                clear_error,
	output logic                accept,
	output logic                fct_req,
	output logic [5:0]          outstanding,
	output logic                credit_error
);
	import spw_pkg::*;

	localparam int depth      = 2 ** depth_log2;
	localparam int slot_width = depth_log2 + 2;

	logic [slot_width-1:0] free_slots;
	logic                  grant_ok;
	logic                  fct_done;

	// A character is taken only against credit
	assign accept   = rx_valid && (outstanding != '0);
	assign fct_done = fct_req && fct_ack;

	// Slots neither filled nor promised to the far end
	assign free_slots = slot_width'(depth) - slot_width'(count)
		- slot_width'(outstanding);

	assign grant_ok = link_enable
		&& (int'(free_slots) >= FCT_CREDIT)
		&& (int'(outstanding) <= MAX_CREDIT - FCT_CREDIT);

	//----------------------------
	// Outstanding credit
	//----------------------------

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			outstanding <= '0;
		end
		else
		begin
			case ({fct_done, accept})
				2'b10:   outstanding <= outstanding + 6'(FCT_CREDIT);
				2'b01:   outstanding <= outstanding - 1'b1;
				2'b11:   outstanding <= outstanding + 6'(FCT_CREDIT - 1);
				default: outstanding <= outstanding;
			endcase
		end
	end

	//----------------------------
	// FCT request and error flag
	//----------------------------

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			fct_req      <= 1'b0;
			credit_error <= 1'b0;
		end
		else
		begin
			if (fct_done)
			begin
				fct_req <= 1'b0;
			end
			else if (!fct_req && grant_ok)
			begin
				fct_req <= 1'b1;
			end

			// A refused character wins over a clear in the same cycle
			if (rx_valid && !accept)
			begin
				credit_error <= 1'b1;
			end
			else if (clear_error)
			begin
				credit_error <= 1'b0;
			end
		end
	end

	credit_bound : assert property (
		@(posedge clock) disable iff (!reset)
		int'(outstanding) <= MAX_CREDIT
	) else $error("Outstanding credit above limit");

endmodule

`default_nettype wire

/* src/spw_rx_apb.sv */
//----------------------------
// APB register slave
// Data pop, status word and link control
//----------------------------
`default_nettype none
`timescale 1ns/100ps

module spw_rx_apb #(
	parameter int depth_log2 = 6
) (
	input  logic                clock,
	input  logic                reset,
	input  spw_pkg::apb_req_t   apb_req,
	output spw_pkg::apb_rsp_t   apb_rsp,
	input  spw_pkg::spw_char_t  head,
	input  logic [depth_log2:0] count,
	input  logic                empty,
	input  logic                full,
	input  logic [5:0]          outstanding,
	input  logic                credit_error,
	output logic                pop,
	output logic                link_enable,
	output logic                clear_error
);
	import spw_pkg::*;

	logic        access;
	logic        is_data;
	logic        is_status;
	logic        is_control;
	logic        bad_addr;
	logic        bad_write;
	logic        ctrl_write;
	logic [31:0] data_word;
	logic [31:0] status_word;

	//----------------------------
	// Address decode
	//----------------------------

	assign access     = apb_req.sel && apb_req.enable;
	assign is_data    = (apb_req.addr == REG_DATA);
	assign is_status  = (apb_req.addr == REG_STATUS);
	assign is_control = (apb_req.addr == REG_CONTROL);
	assign bad_addr   = !(is_data || is_status || is_control);
	// DATA and STATUS are read only
	assign bad_write  = apb_req.write && (is_data || is_status);
	assign ctrl_write = access && apb_req.write && is_control;

	// Single access phase gives a one-cycle pop
	assign pop         = access && !apb_req.write && is_data && !empty;
	assign clear_error = ctrl_write && apb_req.wdata[1];

	//----------------------------
	// Read words
	//----------------------------

	always_comb
	begin
		data_word     = '0;
		data_word[31] = !empty;
		if (!empty)
		begin
			data_word[8:0] = head;
		end

		status_word        = '0;
		status_word[7:0]   = 8'(count);
		status_word[8]     = empty;
		status_word[9]     = full;
		status_word[21:16] = outstanding;
		status_word[24]    = credit_error;
	end

	always_comb
	begin
		apb_rsp        = '0;
		apb_rsp.ready  = access;
		apb_rsp.slverr = access && (bad_addr || bad_write);
		if (access && !apb_req.write)
		begin
			if (is_data)
			begin
				apb_rsp.rdata = data_word;
			end
			else if (is_status)
			begin
				apb_rsp.rdata = status_word;
			end
			else if (is_control)
			begin
				apb_rsp.rdata = {31'b0, link_enable};
			end
		end
	end

	// Control register
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			link_enable <= 1'b0;
		end
		else if (ctrl_write)
		begin
			link_enable <= apb_req.wdata[0];
		end
	end

endmodule

`default_nettype wire

/* src/spw_rx_top.sv */
//----------------------------
// SpaceWire receive path top level
// Link input, FIFO, credit tracker, APB
//----------------------------
`default_nettype none
`timescale 1ns/100ps

module spw_rx_top #(
	parameter int depth_log2 = 6
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               rx_valid,
	input  spw_pkg::spw_char_t rx_char,
	output logic               fct_req,
	input  logic               fct_ack,
	output logic               credit_error,
	input  spw_pkg::apb_req_t  apb_req,
	output spw_pkg::apb_rsp_t  apb_rsp
);
	import spw_pkg::*;

	spw_char_t           fifo_head;
	logic [depth_log2:0] fifo_count;
	logic                fifo_empty;
	logic                fifo_full;
	logic                accept;
	logic                pop;
	logic                link_enable;
	logic                clear_error;
	logic [5:0]          outstanding;

	spw_rx_fifo #(
		.depth_log2 (depth_log2)
	) u_fifo (
		.clock (clock),
		.reset (reset),
		.write (accept),
		.wdata (rx_char),
		.pop   (pop),
		.head  (fifo_head),
		.count (fifo_count),
		.empty (fifo_empty),
		.full  (fifo_full)
	);

	spw_credit_tracker #(
		.depth_log2 (depth_log2)
	) u_tracker (
		.clock        (clock),
		.reset        (reset),
		.rx_valid     (rx_valid),
		.count        (fifo_count),
		.link_enable  (link_enable),
		.fct_ack      (fct_ack),
		.clear_error  (clear_error),
		.accept       (accept),
		.fct_req      (fct_req),
		.outstanding  (outstanding),
		.credit_error (credit_error)
	);

	spw_rx_apb #(
		.depth_log2 (depth_log2)
	) u_apb (
		.clock        (clock),
		.reset        (reset),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.head         (fifo_head),
		.count        (fifo_count),
		.empty        (fifo_empty),
		.full         (fifo_full),
		.outstanding  (outstanding),
		.credit_error (credit_error),
		.pop          (pop),
		.link_enable  (link_enable),
		.clear_error  (clear_error)
	);

endmodule

`default_nettype wire

/* test/spw_rx_tb_apb.svh */
//----------------------------
// APB helpers for the receive testbench
// Transfer setup, expected read words
// and response checks against the model
//----------------------------
`ifndef SPW_RX_TB_APB_SVH
`define SPW_RX_TB_APB_SVH

// Setup phase of a new transfer
task automatic start_access(input logic write, input logic [11:0] addr,
	input logic [31:0] wdata);
	cur_req       = '0;
	cur_req.sel   = 1'b1;
	cur_req.write = write;
	cur_req.addr  = addr;
	cur_req.wdata = wdata;
endtask

task automatic start_read(input logic [11:0] addr);
	start_access(1'b0, addr, 32'h0);
endtask

task automatic start_write(input logic [11:0] addr, input logic [31:0] wdata);
	start_access(1'b1, addr, wdata);
endtask

task automatic start_random_access(input logic allow_control);
	int          roll;
	logic [31:0] wdata;

	roll  = $urandom % 100;
	wdata = $urandom;
	if (roll < 55)
		start_read(REG_DATA);
	else if (roll < 72)
		start_read(REG_STATUS);
	else if (roll < 78)
		start_read(REG_CONTROL);
	else if (roll < 86 && allow_control)
		// Link stays up most of the time, error cleared at random
		start_write(REG_CONTROL, {30'b0, wdata[1], wdata[4:2] != 3'b000});
	else if (roll < 90)
		start_write(REG_DATA, wdata);
	else if (roll < 94)
		start_write(REG_STATUS, wdata);
	else
		// Every offset from 0x00C upward is unmapped
		start_access(roll[0], 12'h00C + 12'($urandom % 4000), wdata);
endtask

// Register word as the model sees it
function automatic logic [31:0] expected_rdata(input logic [11:0] addr);
	logic [31:0] word;

	word = '0;
	if (addr == REG_DATA && model_q.size() != 0)
	begin
		word[31]  = 1'b1;
		word[8:0] = model_q[0];
	end
	else if (addr == REG_STATUS)
	begin
		word[7:0]   = 8'(model_q.size());
		word[8]     = model_q.size() == 0;
		word[9]     = model_q.size() == depth;
		word[21:16] = 6'(model_credit);
		word[24]    = model_err;
	end
	else if (addr == REG_CONTROL)
		word[0] = model_enable;
	return word;
endfunction

// Access phase, before the model takes the edge
task automatic check_response();
	logic        known;
	logic        want_err;
	logic [31:0] want;

	known    = cur_req.addr inside {REG_DATA, REG_STATUS, REG_CONTROL};
	want_err = !known || (cur_req.write && cur_req.addr != REG_CONTROL);
	if (apb_rsp.ready !== 1'b1)
		report_value("apb_rsp.ready", 32'(apb_rsp.ready), 32'd1);
	if (apb_rsp.slverr !== want_err)
		report_value("apb_rsp.slverr", 32'(apb_rsp.slverr), 32'(want_err));
	if (!cur_req.write && known)
	begin
		want = expected_rdata(cur_req.addr);
		if (apb_rsp.rdata !== want)
			report_value($sformatf("apb_rsp.rdata @%h", cur_req.addr), apb_rsp.rdata, want);
		if (cur_req.addr == REG_DATA)
		begin
			data_reads++;
			if (model_q.size() == 0)
				empty_reads++;
		end
		if (cur_req.addr == REG_STATUS)
		begin
			status_reads++;
			if (int'(apb_rsp.rdata[21:16]) > MAX_CREDIT)
			begin
				$display("Outstanding credit in STATUS above the limit at %0t", $time);
				errors++;
			end
		end
	end
endtask

`endif

/* test/spw_rx_tb.sv */
//----------------------------
// SpaceWire receive path testbench
// Random link and APB traffic checked
// against a cycle model of the receiver
//----------------------------
`default_nettype none
`timescale 1ns/100ps

module spw_rx_tb;
	import spw_pkg::*;

	localparam int depth_log2   = 6;
	localparam int depth        = 2 ** depth_log2;
	localparam int num_cycles   = 6000;
	localparam int enable_cycle = 60;
	// Twice the scripted run, in ns
	localparam int watchdog_ns  = (num_cycles + 8) * 4 * 2;

	logic      clock;
	logic      reset;
	logic      rx_valid;
	spw_char_t rx_char;
	logic      fct_req;
	logic      fct_ack;
	logic      credit_error;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;

	// Model state, as the DUT holds it between edges
	spw_char_t model_q[$];
	int        model_credit;
	logic      model_req;
	logic      model_err;
	logic      model_enable;

	// Inputs applied in the current cycle
	logic      cur_valid;
	spw_char_t cur_char;
	logic      cur_ack;
	apb_req_t  cur_req;
	logic      enable_sent;

	int errors;
	int accepted;
	int refused;
	int data_reads;
	int empty_reads;
	int status_reads;

	spw_rx_top #(
		.depth_log2 (depth_log2)
	) uut (
		.clock        (clock),
		.reset        (reset),
		.rx_valid     (rx_valid),
		.rx_char      (rx_char),
		.fct_req      (fct_req),
		.fct_ack      (fct_ack),
		.credit_error (credit_error),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#2 clock = ~clock;
		end
	end

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("ERR %0t %s got %h expected %h", $time, name, got, want);
		errors++;
	endtask

	`include "spw_rx_tb_apb.svh"

	//----------------------------
	// Model
	//----------------------------

	// One rising edge with the applied inputs
	task automatic model_step();
		logic access;
		logic ctrl_write;
		logic pop;
		logic accept;
		logic done;
		logic grant;

		access     = cur_req.sel && cur_req.enable;
		ctrl_write = access && cur_req.write && cur_req.addr == REG_CONTROL;
		pop        = access && !cur_req.write && cur_req.addr == REG_DATA
			&& model_q.size() != 0;
		accept     = cur_valid && model_credit > 0;
		done       = model_req && cur_ack;
		// Room for a whole FCT block beyond what is stored and promised
		grant      = model_enable && model_credit <= MAX_CREDIT - FCT_CREDIT
			&& depth - model_q.size() - model_credit >= FCT_CREDIT;

		if (pop)
			void'(model_q.pop_front());
		if (accept)
		begin
			model_q.push_back(cur_char);
			accepted++;
		end
		else if (cur_valid)
			refused++;

		model_credit = model_credit + (done ? FCT_CREDIT : 0) - (accept ? 1 : 0);
		model_req    = !done && (model_req || grant);

		// A refusal outweighs a clear in the same cycle
		if (cur_valid && !accept)
			model_err = 1'b1;
		else if (ctrl_write && cur_req.wdata[1])
			model_err = 1'b0;
		if (ctrl_write)
			model_enable = cur_req.wdata[0];
	endtask

	// Inputs for the next edge
	task automatic choose_inputs(input int cyc);
		// Mostly with credit, now and then deliberately without
		cur_valid     = ($urandom % 100) < (model_credit > 0 ? 45 : 6);
		cur_char.flag = ($urandom % 8) == 0;
		cur_char.code = 8'($urandom);
		// Transmitter answers after a random delay
		cur_ack       = model_req && ($urandom % 4) == 0;

		if (cur_req.sel && !cur_req.enable)
			cur_req.enable = 1'b1;
		else if (cur_req.sel)
			cur_req = '0;
		else if (!enable_sent && cyc >= enable_cycle)
		begin
			start_write(REG_CONTROL, 32'h1);
			enable_sent = 1'b1;
		end
		else if (($urandom % 2) == 0)
			start_random_access(enable_sent);
	endtask

	//----------------------------
	// Main sequence
	//----------------------------

	initial
	begin
		void'($urandom(87));
		errors       = 0;
		accepted     = 0;
		refused      = 0;
		data_reads   = 0;
		empty_reads  = 0;
		status_reads = 0;
		reset        = 1'b0;
		rx_valid     = 1'b0;
		rx_char      = '0;
		fct_ack      = 1'b0;
		apb_req      = '0;
		cur_valid    = 1'b0;
		cur_char     = '0;
		cur_ack      = 1'b0;
		cur_req      = '0;
		enable_sent  = 1'b0;
		model_credit = 0;
		model_req    = 1'b0;
		model_err    = 1'b0;
		model_enable = 1'b0;

		repeat (8) @(posedge clock);
		reset <= 1'b1;

		for (int cyc = 0; cyc < num_cycles; cyc++)
		begin
			@(negedge clock);
			if (fct_req !== model_req)
				report_value("fct_req", 32'(fct_req), 32'(model_req));
			if (credit_error !== model_err)
				report_value("credit_error", 32'(credit_error), 32'(model_err));
			if (!enable_sent && fct_req === 1'b1)
			begin
				$display("fct_req raised at %0t before the link was enabled", $time);
				errors++;
			end
			if (cur_req.sel && cur_req.enable)
				check_response();
			model_step();

			@(posedge clock);
			choose_inputs(cyc);
			rx_valid <= cur_valid;
			rx_char  <= cur_char;
			fct_ack  <= cur_ack;
			apb_req  <= cur_req;
		end

		$write("Summary: %0d cycles, %0d accepted, %0d refused, ",
			num_cycles, accepted, refused);
		$display("%0d data reads (%0d empty), %0d status reads, %0d errors",
			data_reads, empty_reads, status_reads, errors);
		if (errors == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

	initial
	begin
		#(watchdog_ns);
		$display("Watchdog expired before the test sequence finished");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
src/spw_pkg.sv
src/spw_rx_fifo.sv
src/spw_credit_tracker.sv
src/spw_rx_apb.sv
src/spw_rx_top.sv
test/spw_rx_tb.sv

/* Makefile */
# Verilator build and run of the SpaceWire receive testbench

BIN  := obj_dir/Vspw_rx_tb
SRCS := compile.f $(wildcard src/*.sv test/*.sv test/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module spw_rx_tb \
		-f compile.f -o Vspw_rx_tb

sim.log: $(BIN)
	-./$(BIN) > sim.log 2>&1

run: sim.log
	cat sim.log

check: sim.log
	@if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then \
		echo "Simulation FAILED, see sim.log"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
